//--- hw/hdmi_pkg.sv
package hdmi_pkg;

    // Sizes of a data island packet, all fixed by the HDMI format.
    localparam int subpacket_bits   = 56; // Seven bytes per subpacket.
    localparam int body_bytes       = 28; // Four subpackets of seven bytes.
    localparam int words_per_packet = 32; // One nine-bit word per enabled pixel clock.
    localparam int parity_bits      = 8;  // BCH parity appended to every block.

    // Generator x^8 + x^7 + x^6 + 1, bit-reversed for an LSB-first shift.
    localparam logic [parity_bits-1:0] ecc_poly = 8'b1000_0011;

    // Header codes.
    localparam logic [7:0] pkt_type_null = 8'h00;
    localparam logic [7:0] pkt_type_avi  = 8'h82;
    localparam logic [7:0] avi_version   = 8'h02;
    localparam logic [7:0] avi_length    = 8'h0D;

    // HB0 sits in the low byte since header bit 0 is sent first.
    typedef struct packed {
        logic [7:0] length;   // HB2.
        logic [7:0] version;  // HB1.
        logic [7:0] pkt_type; // HB0.
    } packet_header_t;

    // The builder fills the body byte by byte, the assembler reads whole subpackets.
    // Byte n falls in subpacket n/7 because both views share the same bit order.
    typedef union packed {
        logic [body_bytes-1:0][7:0]     bytes;
        logic [3:0][subpacket_bits-1:0] sub;
    } packet_body_t;

    typedef struct packed {
        packet_body_t   body;   // 224 bits.
        packet_header_t header; // 24 bits.
    } packet_t;

    typedef struct packed {
        logic [1:0] color_space;    // Y1..Y0, RGB or YCbCr format.
        logic [1:0] picture_aspect; // M1..M0.
        logic [3:0] active_format;  // R3..R0.
        logic [7:0] vic;            // Video identification code.
    } avi_config_t;

    // One serialized word, laid out as the TMDS channel bits it feeds.
    typedef struct packed {
        logic [3:0] odd;     // Odd bit of subpackets 3..0.
        logic [3:0] even;    // Even bit of subpackets 3..0.
        logic       hdr_bit; // Header bit for channel 0.
    } island_word_t;

    // Advances the BCH parity by one data bit, LSB of the block first.
    function automatic logic [parity_bits-1:0] next_ecc(
        input logic [parity_bits-1:0] ecc,
        input logic                   data_bit
    );
        logic feedback;
        feedback = ecc[0] ^ data_bit;
        return (ecc >> 1) ^ (feedback ? ecc_poly : '0);
    endfunction

endpackage

//--- hw/infoframe_builder.sv
`timescale 1ns/100ps

module infoframe_builder
    import hdmi_pkg::*;
(
    input  logic        clk_pixel,
    input  logic        arst_n,
    input  logic        send_req,      // One-cycle request to queue an AVI InfoFrame.
    input  avi_config_t avi_cfg,
    input  logic        credit_return, // The assembler freed its queue entry.
    output logic        pkt_valid,
    output packet_t     pkt
);

    logic [1:0] credits;     // Free entries in the assembler queue.
    logic       pending;     // A request waits for a credit.
    logic       credit_ok;   // A credit is usable in this cycle.
    logic       fire;        // Send the packet in this cycle.
    packet_t    avi_pkt;     // AVI packet formed from the current configuration.
    logic [7:0] sum;         // Running byte sum for the checksum.

    // A credit returned in this cycle may be spent at once, so the packet
    // follows the return by a single cycle.
    assign credit_ok = (credits != 2'd0) || credit_return;

    // Requests that arrive while one is pending fold into it.
    assign fire = (send_req || pending) && credit_ok;

    // Packet contents. Body byte n carries data byte PBn, and PB0 is the checksum.
    always_comb
    begin
        avi_pkt = '0;
        avi_pkt.header.pkt_type = pkt_type_avi;
        avi_pkt.header.version  = avi_version;
        avi_pkt.header.length   = avi_length;

        // PB1 holds Y1..Y0 in bits 6..5 and the active format in the low nibble.
        avi_pkt.body.bytes[1] = {1'b0, avi_cfg.color_space, 1'b0, avi_cfg.active_format};
        // PB2 carries the picture aspect in M1..M0.
        avi_pkt.body.bytes[2] = {2'b00, avi_cfg.picture_aspect, 4'b0000};
        avi_pkt.body.bytes[4] = avi_cfg.vic;  // VIC.

        // Everything but the checksum byte enters the sum.
        sum = avi_pkt.header.pkt_type + avi_pkt.header.version + avi_pkt.header.length;
        for (int i = 1; i < body_bytes; i++)
        begin
            sum = sum + avi_pkt.body.bytes[i];
        end

        // The checksum brings the sum over all 31 bytes to zero.
        avi_pkt.body.bytes[0] = 8'd0 - sum;
    end

    // Credit counter and pending request.
    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            credits   <= 2'd1; // The assembler queue holds one packet.
            pending   <= 1'b0;
            pkt_valid <= 1'b0;
        end
        else
        begin
            case ({credit_return, fire})
                2'b10:   credits <= credits + 2'd1; // Credit back, none spent.
                2'b01:   credits <= credits - 2'd1; // Credit spent.
                default: credits <= credits;        // Both or neither.
            endcase

            pending   <= (send_req || pending) && !fire;
            pkt_valid <= fire;
        end
    end

    // The payload is sampled with the request it answers.
    always_ff @(posedge clk_pixel)
    begin
        if (fire)
        begin
            pkt <= avi_pkt;
        end
    end

endmodule

//--- hw/packet_assembler.sv
`timescale 1ns/100ps

module packet_assembler
    import hdmi_pkg::*;
(
    input  logic         clk_pixel,
    input  logic         arst_n,
    input  logic         enable,        // The data island slot is active.
    input  logic         pkt_valid,
    input  packet_t      pkt,
    output logic         credit_return, // Queue entry moved into the shift stage.
    output island_word_t island_word,
    output logic         packet_start
);

    logic [$clog2(words_per_packet)-1:0] count; // Enabled cycles into the packet.

    logic    q_full;  // One-entry queue state.
    packet_t q_pkt;   // Queued packet.
    packet_t sh_pkt;  // Packet being serialized.
    packet_t null_pkt;
    packet_t cur_pkt; // Packet for the current word.
    logic    period_start;
    logic    ecc_phase; // Counts 0 to 23 carry header data.
    logic    sub_phase; // Counts 0 to 27 carry subpacket data.

    logic [4:0][parity_bits-1:0] parity_q;   // Index 4 is the header block.
    logic [4:0][parity_bits-1:0] parity_cur;
    logic [4:0][parity_bits-1:0] parity_nxt;

    logic [$bits(packet_header_t)+parity_bits-1:0] hdr_block; // Header with parity on top.
    logic [3:0][subpacket_bits+parity_bits-1:0]    sub_block; // Subpacket with parity on top.
    island_word_t word_nxt;

    // Null packet is an all-zero header and body.
    always_comb
    begin
        null_pkt = '0;
        null_pkt.header.pkt_type = pkt_type_null;
    end

    assign period_start  = enable && (count == '0);
    assign ecc_phase     = count < (words_per_packet - parity_bits);
    assign sub_phase     = count < (subpacket_bits / 2);
    assign credit_return = period_start && q_full; // The queued packet starts now.

    // At count 0 the new packet is loaded on the same edge, so read it directly.
    assign cur_pkt    = (count == '0) ? (q_full ? q_pkt : null_pkt) : sh_pkt;
    assign parity_cur = (count == '0) ? '0 : parity_q; // Parity restarts each period.

    always_comb
    begin
        hdr_block = {parity_cur[4], cur_pkt.header};
        // The header takes one bit per word.
        parity_nxt[4] = next_ecc(parity_cur[4], cur_pkt.header[count]);
        for (int i = 0; i < 4; i++)
        begin
            sub_block[i] = {parity_cur[i], cur_pkt.body.sub[i]};
            // Subpackets advance two bits per word, so 56 bits finish by count 27.
            parity_nxt[i] = next_ecc(next_ecc(parity_cur[i], sub_block[i][{count, 1'b0}]),
                                     sub_block[i][{count, 1'b1}]);
            word_nxt.even[i] = sub_block[i][{count, 1'b0}];
            word_nxt.odd[i]  = sub_block[i][{count, 1'b1}];
        end
        word_nxt.hdr_bit = hdr_block[count];
    end

    // Control state, parity and the registered outputs.
    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            q_full       <= 1'b0;
            count        <= '0;
            parity_q     <= '0;
            island_word  <= '0;
            packet_start <= 1'b0;
        end
        else
        begin
            if (pkt_valid)
                q_full <= 1'b1;
            else if (credit_return)
                q_full <= 1'b0;

            packet_start <= period_start; // Low whenever enable is low.

            if (enable)
            begin
                count       <= count + 1'b1; // Wraps after word 31.
                island_word <= word_nxt;
                if (ecc_phase)
                    parity_q[4] <= parity_nxt[4];
                if (sub_phase)
                    parity_q[3:0] <= parity_nxt[3:0];
            end
        end
    end

    // Payload registers.
    always_ff @(posedge clk_pixel)
    begin
        if (pkt_valid)
            q_pkt <= pkt;
        if (period_start)
            sh_pkt <= cur_pkt; // Queued or null packet for this period.
    end

endmodule

//--- hw/data_island_top.sv
`timescale 1ns/100ps

module data_island_top
    import hdmi_pkg::*;
(
    input  logic         clk_pixel,
    input  logic         arst_n,
    input  logic         enable,       // Data island slot is active.
    input  logic         send_req,     // Queue one AVI InfoFrame.
    input  avi_config_t  avi_cfg,
    output island_word_t island_word,  // Word toward the TERC4 encoders.
    output logic         packet_start  // First word of a packet is out.
);

    // Credit-controlled link between builder and assembler.
    logic    pkt_valid;
    packet_t pkt;
    logic    credit_return;

    infoframe_builder builder_i (
        .clk_pixel     (clk_pixel),
        .arst_n        (arst_n),
        .send_req      (send_req),
        .avi_cfg       (avi_cfg),
        .credit_return (credit_return),
        .pkt_valid     (pkt_valid),
        .pkt           (pkt)
    );

    // Sends a null packet whenever nothing is queued at the start of a period.
    packet_assembler assembler_i (
        .clk_pixel     (clk_pixel),
        .arst_n        (arst_n),
        .enable        (enable),
        .pkt_valid     (pkt_valid),
        .pkt           (pkt),
        .credit_return (credit_return),
        .island_word   (island_word),
        .packet_start  (packet_start)
    );

endmodule

//--- test/data_island_assert.sv
`timescale 1ns/100ps

module data_island_assert
    import hdmi_pkg::*;
(
    input logic clk_pixel,
    input logic arst_n,
    input logic enable,
    input logic pkt_valid,
    input logic q_full,
    input logic credit_return,
    input logic packet_start
);

    // Enabled cycles into the period, counted apart from the assembler.
    logic [$clog2(words_per_packet)-1:0] slot_count;

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
            slot_count <= '0;
        else if (enable)
            slot_count <= slot_count + 1'b1; // Wraps after 32 enabled cycles.
    end

    // The builder holds no credit while the queue entry is taken.
    no_overflow: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        pkt_valid |-> !q_full)
        else $error("Packet arrived while the assembler queue was full.");

    credit_at_start: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        credit_return |-> (enable && slot_count == '0))
        else $error("Credit returned outside the first word of a period.");

    single_start: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        packet_start |=> !packet_start)
        else $error("packet_start high in two consecutive cycles.");

endmodule

bind packet_assembler data_island_assert assert_i (
    .clk_pixel     (clk_pixel),
    .arst_n        (arst_n),
    .enable        (enable),
    .pkt_valid     (pkt_valid),
    .q_full        (q_full),
    .credit_return (credit_return),
    .packet_start  (packet_start)
);

//--- test/tb_data_island.sv
`timescale 1ns/100ps

module tb_data_island
    import hdmi_pkg::*;
();

    typedef island_word_t [words_per_packet-1:0] word_seq_t; // All 32 words of one period.

    localparam int  planned_packets = 36; // Periods the stimulus below needs at 3 in 4 enables.
    localparam longint timeout_ns = planned_packets * words_per_packet * 4 * 40 + 20000;

    logic         clk_pixel;
    logic         arst_n;
    logic         enable;
    logic         send_req;
    avi_config_t  avi_cfg;
    island_word_t island_word;
    logic         packet_start;

    integer seed = 32'h7e6b;

    // Transaction model of the credit link, advanced once per clock edge.
    int          m_cnt = 0;     // Enabled cycles into the period.
    int          m_credit = 1;  // One queue entry in the assembler.
    logic        m_pend = 1'b0;
    logic        m_valid = 1'b0;
    avi_config_t m_vcfg;
    logic        m_qfull = 1'b0;
    avi_config_t m_qcfg;
    packet_t     exp_q[$];      // Predicted packet of every period, oldest first.

    int           reqs_sent = 0;
    int           periods_done = 0;
    int           avi_seen = 0;
    logic         en_last = 1'b0; // Enable as the DUT sampled it at the last edge.
    int           obs_count = 0;
    int           word_idx = 0;
    logic         started = 1'b0;
    packet_t      cur_pkt;
    word_seq_t    cur_words;

    data_island_top dut_i (
        .clk_pixel    (clk_pixel),
        .arst_n       (arst_n),
        .enable       (enable),
        .send_req     (send_req),
        .avi_cfg      (avi_cfg),
        .island_word  (island_word),
        .packet_start (packet_start)
    );

    initial
    begin
        clk_pixel = 1'b0;
        forever #20 clk_pixel = ~clk_pixel; // 25 MHz pixel clock.
    end

    // AVI InfoFrame as the format defines it; PB0 balances the byte sum.
    function automatic packet_t avi_ref(input avi_config_t cfg);
        packet_t p;
        int      sum;
        p = '0;
        p.header.pkt_type = pkt_type_avi;
        p.header.version  = avi_version;
        p.header.length   = avi_length;
        p.body.bytes[1] = ({6'd0, cfg.color_space} << 5) | {4'd0, cfg.active_format};
        p.body.bytes[2] = {6'd0, cfg.picture_aspect} << 4;
        p.body.bytes[4] = cfg.vic;
        sum = p.header.pkt_type + p.header.version + p.header.length;
        for (int n = 1; n < body_bytes; n++)
            sum = sum + p.body.bytes[n];
        p.body.bytes[0] = (256 - (sum % 256)) % 256;
        return p;
    endfunction

    // Expected words of one period: every block LSB first, parity on top of its data.
    function automatic word_seq_t ref_words(input packet_t p);
        logic [parity_bits-1:0]      hpar;
        logic [3:0][parity_bits-1:0] spar;
        logic [31:0]                 hblk;
        logic [3:0][63:0]            sblk;
        word_seq_t                   w;
        hpar = '0;
        spar = '0;
        for (int b = 0; b < 24; b++)
            hpar = next_ecc(hpar, p.header[b]);
        hblk = {hpar, p.header};
        for (int i = 0; i < 4; i++)
        begin
            for (int b = 0; b < subpacket_bits; b++)
                spar[i] = next_ecc(spar[i], p.body.sub[i][b]);
            sblk[i] = {spar[i], p.body.sub[i]};
        end
        for (int k = 0; k < words_per_packet; k++)
        begin
            w[k].hdr_bit = hblk[k];
            for (int i = 0; i < 4; i++)
            begin
                w[k].even[i] = sblk[i][2*k];   // Two bits per subpacket and word.
                w[k].odd[i]  = sblk[i][2*k+1];
            end
        end
        return w;
    endfunction

    task automatic compare_word(input int idx, input island_word_t got, input island_word_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: word %0d is %h, expected %h", $time, idx, got, exp);
            $display("** FAIL **");
            $fatal(1, "Stopped at the first wrong island word.");
        end
    endtask

    task automatic compare_start(input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: packet_start is %b, expected %b", $time, got, exp);
            $display("** FAIL **");
            $fatal(1, "Stopped at the first framing error.");
        end
    endtask

    // One DUT edge seen through the credit rule, using the inputs sampled at that edge.
    task automatic model_edge();
        logic    period;
        logic    cr;
        logic    fire;
        packet_t np;
        np = '0;
        np.header.pkt_type = pkt_type_null;
        period = enable && (m_cnt == 0);
        cr = period && m_qfull; // Queued packet leaves, so the credit comes back.
        if (period)
            exp_q.push_back(m_qfull ? avi_ref(m_qcfg) : np);
        fire = (send_req || m_pend) && (m_credit > 0 || cr);
        m_credit = m_credit + int'(cr) - int'(fire);
        m_pend = (send_req || m_pend) && !fire; // Later requests merge into a pending one.
        if (m_valid)
        begin
            m_qfull = 1'b1;
            m_qcfg = m_vcfg;
        end
        else if (cr)
            m_qfull = 1'b0;
        m_valid = fire;
        m_vcfg = avi_cfg;
        if (enable)
            m_cnt = (m_cnt + 1) % words_per_packet;
    endtask

    task automatic step(input logic req, input avi_config_t cfg);
        @(posedge clk_pixel);
        model_edge();
        enable   <= ($random(seed) & 3) != 0; // Slot active about 3 in 4 cycles.
        send_req <= req;
        if (req)
        begin
            avi_cfg <= cfg; // Held until the next request.
            reqs_sent++;
        end
    endtask

    task automatic run_idle(input int n);
        repeat (n) step(1'b0, '0);
    endtask

    task automatic request_random();
        logic [31:0] rnd;
        rnd = $random(seed);
        step(1'b1, rnd[15:0]);
    endtask

    initial
    begin
        int target;
        arst_n   = 1'b0;
        enable   = 1'b0;
        send_req = 1'b0;
        avi_cfg  = '0;
        repeat (5) @(posedge clk_pixel);
        arst_n <= 1'b1;

        run_idle(160);                                       // Null packets only.
        step(1'b1, {2'b01, 2'b10, 4'b1000, 8'd16});          // One fixed request.
        run_idle(160);
        repeat (4)
        begin
            request_random();                                // Parity over varied bodies.
            run_idle(160);
        end
        request_random();                                    // Two requests back to back.
        run_idle(3);
        request_random();
        run_idle(300);

        target = periods_done + 2; // Let two more whole periods through.
        while (periods_done < target)
            run_idle(1);
        if (avi_seen == reqs_sent)
        begin
            $display("** PASS **");
            $finish;
        end
        else
        begin
            $display("Sent %0d requests but saw %0d AVI periods.", reqs_sent, avi_seen);
            $display("** FAIL **");
            $fatal(1, "Requests lost or duplicated.");
        end
    end

    // Outputs change on the rising edge and are read at the falling edge.
    always @(negedge clk_pixel)
    begin
        if (arst_n && en_last)
        begin
            compare_start(packet_start, obs_count == 0);
            if (obs_count == 0 && exp_q.size() == 0)
            begin
                $display("A period started at %0t with no packet predicted for it.", $time);
                $display("** FAIL **");
                $fatal(1, "Model and DUT out of step.");
            end
            else if (obs_count == 0)
            begin
                cur_pkt   = exp_q.pop_front();
                cur_words = ref_words(cur_pkt);
                word_idx  = 0;
                started   = 1'b1;
            end
            else
                word_idx = word_idx + 1;
            compare_word(word_idx, island_word, cur_words[word_idx]);
            if (word_idx == words_per_packet - 1)
            begin
                periods_done++;
                if (cur_pkt.header.pkt_type == pkt_type_avi)
                    avi_seen++;
            end
            obs_count = (obs_count + 1) % words_per_packet;
        end
        else if (arst_n)
        begin
            compare_start(packet_start, 1'b0);
            if (started)
                compare_word(word_idx, island_word, cur_words[word_idx]); // Word must hold.
            else
                compare_word(0, island_word, '0); // Reset value until the first word.
        end
        en_last = enable;
    end

    initial
    begin
        #(timeout_ns);
        $display("Watchdog expired after %0d ns before the test finished.", timeout_ns);
        $display("** FAIL **");
        $fatal(1, "Simulation timed out.");
    end

endmodule

//--- vlog.f
hw/hdmi_pkg.sv
hw/infoframe_builder.sv
hw/packet_assembler.sv
hw/data_island_top.sv
test/data_island_assert.sv
test/tb_data_island.sv

//--- Bender.yml
package:
  name: hdmi_data_island

sources:
  - files:
      - hw/hdmi_pkg.sv
      - hw/infoframe_builder.sv
      - hw/packet_assembler.sv
      - hw/data_island_top.sv
  - target: test
    files:
      - test/data_island_assert.sv
      - test/tb_data_island.sv
